// File: Makefile
# Verilator build and run for the branch resolution unit testbench
VERILATOR ?= verilator
TOP       ?= branch_unit_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/branch_stimulus.txt
# name rst instr pc rs1 rs2 rvc pred_addr pred_valid pred_taken
# then expected valid target taken mispredict exception; flags binary, the rest hex
beq_taken   0 00208863 1000 5 5 0 1010 1 1 1 1010 1 0 0
beq_not     0 00208863 1000 5 6 0 1010 1 0 1 1004 0 0 0
bne_taken   0 00209863 1000 5 6 0 1010 1 1 1 1010 1 0 0
bne_not     0 00209863 1000 7 7 0 1010 1 0 1 1004 0 0 0
blt_taken   0 0020c863 1000 ffffffffffffffff 1 0 1010 1 1 1 1010 1 0 0
blt_not     0 0020c863 1000 7fffffffffffffff 8000000000000000 0 1010 1 0 1 1004 0 0 0
bge_taken   0 0020d863 1000 0 8000000000000000 0 1010 1 1 1 1010 1 0 0
bge_not     0 0020d863 1000 ffffffffffffffff 0 0 1010 1 0 1 1004 0 0 0
bltu_taken  0 0020e863 1000 7fffffffffffffff 8000000000000000 0 1010 1 1 1 1010 1 0 0
bltu_not    0 0020e863 1000 ffffffffffffffff 1 0 1010 1 0 1 1004 0 0 0
bgeu_taken  0 0020f863 1000 ffffffffffffffff ffffffffffffffff 0 1010 1 1 1 1010 1 0 0
bgeu_not    0 0020f863 1000 0 1 0 1010 1 0 1 1004 0 0 0
bne_back    0 fe209ce3 1000 1 2 0 ff8 1 1 1 ff8 1 0 0
jal         0 100000ef 1000 0 0 0 1100 1 1 1 1100 1 0 0
jalr        0 008280e7 1000 2000 0 0 2008 1 1 1 2008 1 0 0
jalr_neg    0 ffc280e7 1000 3000 0 0 2ffc 1 1 1 2ffc 1 0 0
rvc_not     0 00208863 1000 5 6 1 1010 1 0 1 1002 0 0 0
rvc_taken   0 00208863 1000 5 5 1 1010 1 1 1 1010 1 0 0
mp_addr     0 00208863 1000 5 5 0 1020 1 1 1 1010 1 1 0
mp_dir      0 00209863 1000 7 7 0 1010 1 1 1 1004 0 1 0
mp_invalid  0 100000ef 1000 0 0 0 1100 0 1 1 1100 1 1 0
mis_branch  0 00208863 1002 5 5 0 0 0 0 1 1012 1 0 1
mis_jalr    0 008280e7 1000 2002 0 0 0 0 0 1 200a 1 0 1
mis_not     0 00208863 1002 5 6 0 0 0 0 1 1006 0 0 0
reset_line  1 00208863 1000 5 5 0 1010 1 1 0 0 0 0 0
non_branch  0 00100093 1000 5 5 0 1010 1 1 0 0 0 0 0
after_reset 0 00208863 1000 5 5 0 1010 1 1 1 1010 1 0 0

// File: bench/branch_unit_checker.sv
// concurrent checks on the branch unit outputs, attached by bind
// sampled on the rising clock, a reset edge must leave the next cycle idle
`timescale 1ns/1ps
`default_nettype none

module branch_unit_checker import branch_pkg::*; (
    input logic           clk_i,
    input logic           reset_i,
    input branchpredict_t branchpredict_i,
    input exception_t     branch_ex_i
);

    // reset clears the issue register, so nothing is valid one cycle later
    reset_idle: assert property (@(posedge clk_i)
        reset_i |=> !branchpredict_i.valid && !branch_ex_i.valid)
        else $error("result valid right after a reset cycle");

    // an exception always belongs to an issued transfer
    ex_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        branch_ex_i.valid |-> branchpredict_i.valid)
        else $error("exception raised without a valid result");

    // misaligned targets skip the prediction check
    ex_not_mispredict: assert property (@(posedge clk_i) disable iff (reset_i)
        branch_ex_i.valid |-> !branchpredict_i.is_mispredict)
        else $error("exception and mispredict flagged together");

endmodule

`default_nettype wire

// File: bench/branch_unit_tb.sv
// testbench for the branch resolution unit
// expects to be run from the project root
// vectors and expected values come from bench/branch_stimulus.txt
// one vector is issued per cycle and checked one cycle later
`timescale 1ns/1ps
`default_nettype none

`include "branch_consts.svh"

module branch_unit_tb import riscv_instr_pkg::*, branch_pkg::*; ();

    localparam int MAX_TESTS = 64;

    // one line of the stimulus file with inputs first and expected values last
    typedef struct packed {
        logic [8*16-1:0]     name;
        logic                rst;
        logic [`BR_ILEN-1:0] instr;
        logic [`BR_XLEN-1:0] pc;
        logic [`BR_XLEN-1:0] rs1;
        logic [`BR_XLEN-1:0] rs2;
        logic                compressed;
        branch_prediction_t  prediction;
        logic                exp_valid;
        logic [`BR_XLEN-1:0] exp_target;
        logic                exp_taken;
        logic                exp_mispredict;
        logic                exp_exception;
    } test_vec_t;

    logic                clk;
    logic                reset;
    logic                valid;
    instr_u              instr;
    logic [`BR_XLEN-1:0] pc;
    logic [`BR_XLEN-1:0] rs1_data;
    logic [`BR_XLEN-1:0] rs2_data;
    logic                compressed;
    branch_prediction_t  prediction;
    branchpredict_t      branchpredict;
    exception_t          branch_ex;

    test_vec_t vectors [0:MAX_TESTS-1];
    int        num_tests;
    int        error_count;
    int        failed_tests;
    bit        loaded;

    branch_unit u_dut (
        .clk_i           (clk),
        .reset_i         (reset),
        .valid_i         (valid),
        .instr_i         (instr),
        .pc_i            (pc),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .is_compressed_i (compressed),
        .prediction_i    (prediction),
        .branchpredict_o (branchpredict),
        .branch_ex_o     (branch_ex)
    );

    bind branch_unit branch_unit_checker u_checker (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .branchpredict_i (branchpredict_o),
        .branch_ex_i     (branch_ex_o)
    );

    // 100 ns period
    always #50 clk = ~clk;

    task automatic load_vectors(input int fd);
        logic [8*200-1:0]    header;
        logic [8*16-1:0]     name;
        logic                rst;
        logic                comp;
        logic                pv;
        logic                pt;
        logic                ev;
        logic                etk;
        logic                emis;
        logic                eex;
        logic [`BR_ILEN-1:0] ins;
        logic [`BR_XLEN-1:0] vpc;
        logic [`BR_XLEN-1:0] vrs1;
        logic [`BR_XLEN-1:0] vrs2;
        logic [`BR_XLEN-1:0] paddr;
        logic [`BR_XLEN-1:0] etgt;
        int                  code;
        // the two comment lines at the top name the columns
        code = $fgets(header, fd);
        code = $fgets(header, fd);
        code = $fscanf(fd, "%s %b %h %h %h %h %b %h %b %b %b %h %b %b %b\n", name, rst, ins,
                       vpc, vrs1, vrs2, comp, paddr, pv, pt, ev, etgt, etk, emis, eex);
        while (code == 15 && num_tests < MAX_TESTS) begin
            vectors[num_tests] = {name, rst, ins, vpc, vrs1, vrs2, comp, paddr, pv, pt,
                                  ev, etgt, etk, emis, eex};
            num_tests++;
            code = $fscanf(fd, "%s %b %h %h %h %h %b %h %b %b %b %h %b %b %b\n", name, rst, ins,
                           vpc, vrs1, vrs2, comp, paddr, pv, pt, ev, etgt, etk, emis, eex);
        end
    endtask

    task automatic drive_vector(input test_vec_t vec);
        reset      = vec.rst;
        valid      = 1'b1;
        instr      = vec.instr;
        pc         = vec.pc;
        rs1_data   = vec.rs1;
        rs2_data   = vec.rs2;
        compressed = vec.compressed;
        prediction = vec.prediction;
    endtask

    task automatic compare_field(input test_vec_t vec, input string field,
                                 input logic [`BR_XLEN-1:0] expected,
                                 input logic [`BR_XLEN-1:0] actual, inout int mismatches);
        if (expected !== actual) begin
            $display("FAILED %0s %0s expected %h actual %h", vec.name, field, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_vector(input test_vec_t vec);
        int mismatches;
        mismatches = 0;
        // flags must also stay low on idle lines
        compare_field(vec, "valid", 64'(vec.exp_valid), 64'(branchpredict.valid), mismatches);
        compare_field(vec, "mispredict", 64'(vec.exp_mispredict),
                      64'(branchpredict.is_mispredict), mismatches);
        compare_field(vec, "exception", 64'(vec.exp_exception), 64'(branch_ex.valid), mismatches);
        if (vec.exp_valid) begin
            compare_field(vec, "target", vec.exp_target, branchpredict.target_address, mismatches);
            compare_field(vec, "taken", 64'(vec.exp_taken), 64'(branchpredict.is_taken),
                          mismatches);
            compare_field(vec, "pc", vec.pc, branchpredict.pc, mismatches);
        end
        // a trapping target is also the expected tval
        // instruction address misaligned is cause code 0
        if (vec.exp_exception) begin
            compare_field(vec, "tval", vec.exp_target, branch_ex.tval, mismatches);
            compare_field(vec, "cause", 64'd0, branch_ex.cause, mismatches);
        end
        if (mismatches == 0) begin
            $display("test %0s passed", vec.name);
        end else begin
            $display("test %0s failed with %0d mismatches", vec.name, mismatches);
            error_count += mismatches;
            failed_tests++;
        end
    endtask

    initial begin
        int fd;
        clk          = 1'b0;
        reset        = 1'b1;
        valid        = 1'b0;
        instr        = '0;
        pc           = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        compressed   = 1'b0;
        prediction   = '0;
        num_tests    = 0;
        error_count  = 0;
        failed_tests = 0;
        fd = $fopen("bench/branch_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open bench/branch_stimulus.txt");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            load_vectors(fd);
            $fclose(fd);
            loaded = 1'b1;
            if (num_tests == 0) begin
                $display("stimulus file holds no test vectors");
                error_count++;
            end
            // reset held over two rising edges
            repeat (2) @(posedge clk);
            #1;
            reset = 1'b0;
            // vector i is driven while vector i-1 sits in the issue register
            for (int i = 0; i <= num_tests; i++) begin
                @(posedge clk);
                #1;
                if (i > 0) begin
                    check_vector(vectors[i-1]);
                end
                if (i < num_tests) begin
                    drive_vector(vectors[i]);
                end else begin
                    valid = 1'b0;
                end
            end
            $display("tests %0d passed %0d failed %0d mismatches %0d", num_tests,
                     num_tests - failed_tests, failed_tests, error_count);
            if (error_count == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

    // watchdog bound is the vector count plus 10 cycles
    initial begin
        wait (loaded);
        #((num_tests + 10) * 100);
        $display("timeout: run did not finish within %0d cycles", num_tests + 10);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: include/branch_consts.svh
// shared constants for the branch resolution unit
// widths are fixed by the 64-bit ISA and are not meant to be overridden
// step and cause values are sized to the data width
`ifndef BRANCH_CONSTS_SVH
`define BRANCH_CONSTS_SVH

// data and address width
`define BR_XLEN 64

// instruction word width, uncompressed encoding only
`define BR_ILEN 32

// instruction address misaligned, as in the privileged spec
`define BR_CAUSE_INSTR_MISALIGNED 64'd0

// fall-through increments for compressed and full-size instructions
`define BR_STEP_RVC 64'd2
`define BR_STEP_RVI 64'd4

`endif

// File: rtl/branch_comparator.sv
// branch condition evaluation, purely combinational
// jumps are always taken; the two unused funct3 codes resolve not-taken
`timescale 1ns/1ps
`default_nettype none

module branch_comparator import riscv_instr_pkg::*, branch_pkg::*; (
    input  branch_issue_t issue_i,
    output logic          taken_o
);

    logic equal;
    logic less_signed;
    logic less_unsigned;

    // one compare of each kind, shared by the condition and its inverse
    assign equal         = (issue_i.cmp_a == issue_i.cmp_b);
    assign less_signed   = ($signed(issue_i.cmp_a) < $signed(issue_i.cmp_b));
    assign less_unsigned = (issue_i.cmp_a < issue_i.cmp_b);

    always_comb begin
        if (issue_i.is_jump) begin
            taken_o = 1'b1;
        end else begin
            case (issue_i.funct3)
                BEQ:     taken_o = equal;
                BNE:     taken_o = !equal;
                BLT:     taken_o = less_signed;
                BGE:     taken_o = !less_signed;
                BLTU:    taken_o = less_unsigned;
                BGEU:    taken_o = !less_unsigned;
                default: taken_o = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/branch_engine.sv
// target calculation, misprediction check and misaligned-target exception
// alignment is checked to 4 bytes, so a 2-byte aligned target traps
// the exception is only raised for a valid, taken transfer
`timescale 1ns/1ps
`default_nettype none

`include "branch_consts.svh"

module branch_engine import branch_pkg::*; (
    input  branch_issue_t  issue_i,
    input  logic           comparison_result_i,
    output branchpredict_t branchpredict_o,
    output exception_t     branch_ex_o
);

    logic [`BR_XLEN-1:0] target_address;
    logic [`BR_XLEN-1:0] next_pc;
    logic                target_aligned;

    // plain 64-bit add, wraps like the ISA does
    assign target_address = issue_i.operand_a + issue_i.operand_b;
    // step chosen first, then added to the pc
    assign next_pc        = issue_i.pc + (issue_i.is_compressed ? `BR_STEP_RVC : `BR_STEP_RVI);
    assign target_aligned = (target_address[1:0] == 2'b00);

    always_comb begin
        branchpredict_o.valid          = issue_i.valid;
        branchpredict_o.pc             = issue_i.pc;
        // taken goes to the target, otherwise to the next instruction
        branchpredict_o.target_address = comparison_result_i ? target_address : next_pc;
        branchpredict_o.is_taken       = comparison_result_i;
        branchpredict_o.is_mispredict  = 1'b0;

        // a misaligned target is reported as an exception instead
        if (issue_i.valid && target_aligned) begin
            // wrong address, wrong direction, or the front end missed the branch
            if ((target_address != issue_i.prediction.predict_address)
                || (issue_i.prediction.predict_taken != comparison_result_i)
                || !issue_i.prediction.predict_valid) begin
                branchpredict_o.is_mispredict = 1'b1;
            end
        end
    end

    always_comb begin
        branch_ex_o.cause = `BR_CAUSE_INSTR_MISALIGNED;
        // tval carries the faulting target for the trap handler
        branch_ex_o.tval  = target_address;
        branch_ex_o.valid = issue_i.valid && comparison_result_i && !target_aligned;
    end

endmodule

`default_nettype wire

// File: rtl/branch_issue.sv
// issue register, takes one control-transfer instruction per cycle
// no stall input, a new instruction overwrites the previous one every edge
// opcodes other than BRANCH, JAL and JALR are issued with valid low
`timescale 1ns/1ps
`default_nettype none

`include "branch_consts.svh"

module branch_issue import riscv_instr_pkg::*, branch_pkg::*; (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                valid_i,
    input  instr_u              instr_i,
    input  logic [`BR_XLEN-1:0] pc_i,
    input  logic [`BR_XLEN-1:0] rs1_data_i,
    input  logic [`BR_XLEN-1:0] rs2_data_i,
    input  logic                is_compressed_i,
    input  branch_prediction_t  prediction_i,
    output branch_issue_t       issue_o
);

    branch_issue_t       issue_d;
    branch_issue_t       issue_q;
    logic [`BR_XLEN-1:0] imm_b;
    logic [`BR_XLEN-1:0] imm_j;
    logic [`BR_XLEN-1:0] imm_i;

    // sign-extended immediates, one per format view
    // B and J immediates are in units of two bytes, so bit 0 is zero
    assign imm_b = {{(`BR_XLEN-13){instr_i.b.imm12}}, instr_i.b.imm12, instr_i.b.imm11,
                    instr_i.b.imm10_5, instr_i.b.imm4_1, 1'b0};
    assign imm_j = {{(`BR_XLEN-21){instr_i.j.imm20}}, instr_i.j.imm20, instr_i.j.imm19_12,
                    instr_i.j.imm11, instr_i.j.imm10_1, 1'b0};
    assign imm_i = {{(`BR_XLEN-12){instr_i.i.imm11_0[11]}}, instr_i.i.imm11_0};

    always_comb begin
        // fields common to every control transfer
        issue_d.valid         = 1'b0;
        issue_d.pc            = pc_i;
        issue_d.cmp_a         = rs1_data_i;
        issue_d.cmp_b         = rs2_data_i;
        issue_d.funct3        = instr_i.b.funct3;
        issue_d.is_compressed = is_compressed_i;
        issue_d.prediction    = prediction_i;
        // default adder inputs, also what an unknown opcode carries
        issue_d.operand_a     = pc_i;
        issue_d.operand_b     = imm_b;
        issue_d.is_jump       = 1'b0;

        // the opcode sits in the same bits in all views
        case (instr_i.b.opcode)
            BRANCH: begin
                issue_d.valid = valid_i;
            end
            JAL: begin
                issue_d.valid     = valid_i;
                issue_d.operand_b = imm_j;
                issue_d.is_jump   = 1'b1;
            end
            JALR: begin
                // register-relative target
                issue_d.valid     = valid_i;
                issue_d.operand_a = rs1_data_i;
                issue_d.operand_b = imm_i;
                issue_d.is_jump   = 1'b1;
            end
            default: begin
                issue_d.valid = 1'b0;
            end
        endcase
    end

    // only valid is cleared, the payload just holds during reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            issue_q.valid <= 1'b0;
        end else begin
            issue_q <= issue_d;
        end
    end

    assign issue_o = issue_q;

endmodule

`default_nettype wire

// File: rtl/branch_pkg.sv
// types carried between the stages of the branch resolution unit
// funct3 is kept as the branch enum, so this package depends on riscv_instr_pkg
`default_nettype none

`include "branch_consts.svh"

package branch_pkg;

    import riscv_instr_pkg::*;

    // what the front end guessed for this instruction
    typedef struct packed {
        logic [`BR_XLEN-1:0] predict_address;
        logic                predict_valid;
        logic                predict_taken;
    } branch_prediction_t;

    // registered issue bus, adder operands and compare operands kept apart
    typedef struct packed {
        logic                valid;
        logic [`BR_XLEN-1:0] pc;
        logic [`BR_XLEN-1:0] operand_a;
        logic [`BR_XLEN-1:0] operand_b;
        logic [`BR_XLEN-1:0] cmp_a;
        logic [`BR_XLEN-1:0] cmp_b;
        br_funct3_e          funct3;
        logic                is_jump;
        logic                is_compressed;
        branch_prediction_t  prediction;
    } branch_issue_t;

    // resolved outcome handed back to the PC generator
    typedef struct packed {
        logic                valid;
        logic [`BR_XLEN-1:0] pc;
        logic [`BR_XLEN-1:0] target_address;
        logic                is_taken;
        logic                is_mispredict;
    } branchpredict_t;

    // exception record, tval holds the faulting target
    typedef struct packed {
        logic [`BR_XLEN-1:0] cause;
        logic [`BR_XLEN-1:0] tval;
        logic                valid;
    } exception_t;

endpackage

`default_nettype wire

// File: rtl/branch_unit.sv
// branch resolution unit top level
// one cycle latency, accepts an instruction every cycle, no back-pressure
// the consumer must take every result in the cycle it is valid
`timescale 1ns/1ps
`default_nettype none

`include "branch_consts.svh"

module branch_unit import riscv_instr_pkg::*, branch_pkg::*; (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                valid_i,
    input  instr_u              instr_i,
    input  logic [`BR_XLEN-1:0] pc_i,
    input  logic [`BR_XLEN-1:0] rs1_data_i,
    input  logic [`BR_XLEN-1:0] rs2_data_i,
    input  logic                is_compressed_i,
    input  branch_prediction_t  prediction_i,
    output branchpredict_t      branchpredict_o,
    output exception_t          branch_ex_o
);

    // registered operands from the issue stage
    branch_issue_t issue;
    // branch condition outcome, forced high for jumps
    logic          taken;

    branch_issue u_issue (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .valid_i         (valid_i),
        .instr_i         (instr_i),
        .pc_i            (pc_i),
        .rs1_data_i      (rs1_data_i),
        .rs2_data_i      (rs2_data_i),
        .is_compressed_i (is_compressed_i),
        .prediction_i    (prediction_i),
        .issue_o         (issue)
    );

    branch_comparator u_cmp (
        .issue_i (issue),
        .taken_o (taken)
    );

    branch_engine u_engine (
        .issue_i             (issue),
        .comparison_result_i (taken),
        .branchpredict_o     (branchpredict_o),
        .branch_ex_o         (branch_ex_o)
    );

endmodule

`default_nettype wire

// File: rtl/riscv_instr_pkg.sv
// instruction format views for control-transfer decoding
// only the opcodes and funct3 codes the branch unit needs are enumerated
`default_nettype none

package riscv_instr_pkg;

    // major opcodes of control-transfer instructions
    typedef enum logic [6:0] {
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } opcode_e;

    // conditional branch kinds, 3'b010 and 3'b011 are unused
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } br_funct3_e;

    // B-type, immediate scattered over two fields
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        br_funct3_e funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } btype_t;

    // J-type, used by JAL
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } jtype_t;

    // I-type, used by JALR
    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } itype_t;

    // one word, three decodings; the opcode field picks the one that applies
    typedef union packed {
        btype_t b;
        jtype_t j;
        itype_t i;
    } instr_u;

endpackage

`default_nettype wire

// File: src.f
+incdir+include
rtl/riscv_instr_pkg.sv
rtl/branch_pkg.sv
rtl/branch_issue.sv
rtl/branch_comparator.sv
rtl/branch_engine.sv
rtl/branch_unit.sv
bench/branch_unit_checker.sv
bench/branch_unit_tb.sv
